// File: tb.f
+incdir+.
cpu_mem_pkg.sv
mem_bus_pkg.sv
addr_select.sv
byte_sequencer.sv
fetch_capture.sv
memctrl_top.sv
tb_clkgen.sv
tb_memctrl.sv

// File: Bender.yml
package:
  name: memctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_mem_pkg.sv
      - mem_bus_pkg.sv
      - addr_select.sv
      - byte_sequencer.sv
      - fetch_capture.sv
      - memctrl_top.sv
      - target: test
        files:
          - tb_clkgen.sv
          - tb_memctrl.sv

// File: tb_memctrl.sv
// memctrl_top testbench with memory model, stimulus table, compare tasks and watchdog
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module tb_memctrl
    import cpu_mem_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int NROWS           = 19;
    localparam int CLK_PERIOD      = 4;
    localparam int WATCHDOG_CYCLES = NROWS * 10 + 50;

    typedef struct packed {
        mem_req_t    req;
        addr_regs_t  regs;
        logic [15:0] wdata;
        logic [3:0]  halt_n;  // halted edges right after acceptance
        logic [3:0]  exp_lat; // edges from acceptance to done or 0 when dropped
        logic        exp_is_op;
        logic        exp_is_vec;
    } stim_row_t;

    logic                   clk;
    logic                   rst;
    logic                   halt;
    logic                   req_valid;
    logic                   busy;
    logic                   done;
    logic                   we;
    mem_req_t               req;
    addr_regs_t             regs;
    mem_rsp_t               rsp;
    logic [`MEMCTRL_AW-1:0] wdata;
    logic [`MEMCTRL_AW-1:0] addr;
    logic [`MEMCTRL_DW-1:0] din;
    logic [`MEMCTRL_DW-1:0] dout;

    logic [7:0] mem [0:65535];    // bus memory written by the dut
    logic [7:0] shadow [0:65535]; // what memory should hold
    stim_row_t  rows [NROWS];
    mem_rsp_t   last_rsp = '0;    // expected rsp after the latest done
    int         err_cnt  = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(2)) clkgen_i (.clk, .rst);

    memctrl_top dut_i (
        .clk, .rst, .halt, .req_valid, .req, .regs, .wdata, .din,
        .busy, .done, .rsp, .addr, .dout, .we
    );

    assign din = mem[addr]; // combinational read port
    always @(posedge clk) begin
        if (we) mem[addr] <= dout;
    end

    function automatic mem_req_t mk_req(addr_src_e src, logic wide, logic write,
                                        logic idx_adv, logic [3:0] intvec);
        return '{src, wide, write, idx_adv, intvec, 2'b00};
    endfunction

    // start address per source with the vector code decoded highest bit first
    function automatic logic [15:0] exp_start_addr(mem_req_t r, addr_regs_t g);
        case (r.src)
            SRC_X:    return g.x;
            SRC_Y:    return g.y;
            SRC_PUSH: return g.sp - (r.wide ? 16'd2 : 16'd1);
            SRC_PULL: return g.sp;
            SRC_IDX:  return g.idx_base + 16'(r.idx_adv);
            SRC_VEC: begin
                casez (r.intvec)
                    4'b1???: return `MEMCTRL_VEC_RST;
                    4'b01??: return `MEMCTRL_VEC_NMI;
                    4'b001?: return `MEMCTRL_VEC_FIRQ;
                    default: return `MEMCTRL_VEC_IRQ;
                endcase
            end
            default:  return g.pc;
        endcase
    endfunction

    function automatic mem_rsp_t exp_response(stim_row_t r, logic [15:0] ea);
        mem_rsp_t e;
        e        = last_rsp; // writes leave data as it was
        e.is_op  = r.exp_is_op;
        e.is_vec = r.exp_is_vec;
        if (!r.req.write) begin
            if (r.req.wide || r.req.src == SRC_VEC) begin
                e.data.bytes.hi = shadow[ea]; // big-endian pair
                e.data.bytes.lo = shadow[ea + 16'd1];
            end else begin
                e.data.word = {8'h00, shadow[ea]};
            end
        end
        return e;
    endfunction

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        if (got.data.word !== exp.data.word) begin
            $display("ERROR rsp.data got %h expected %h", got.data.word, exp.data.word);
            err_cnt++;
        end
        if (got.is_op !== exp.is_op || got.is_vec !== exp.is_vec) begin
            $display("ERROR rsp.is_op/is_vec got %h/%h expected %h/%h",
                     got.is_op, got.is_vec, exp.is_op, exp.is_vec);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR addr got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR done latency got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic run_row(input int idx);
        stim_row_t   r;
        mem_rsp_t    exp;
        logic [15:0] ea;
        int          lat;
        int          errs_before;
        bit          seen;
        r           = rows[idx];
        errs_before = err_cnt;
        ea          = exp_start_addr(r.req, r.regs);
        // a dropped request leaves rsp as it was
        exp         = (r.exp_lat == 0) ? last_rsp : exp_response(r, ea);
        @(posedge clk);
        check_flag("done", done, 1'b0); // previous pulse is one cycle
        #1;
        req       = r.req;
        regs      = r.regs;
        wdata     = r.wdata;
        req_valid = 1'b1;
        @(posedge clk); // acceptance edge
        check_flag("busy", busy, 1'b0);
        #1;
        req_valid = 1'b0;
        halt      = (r.halt_n != 0);
        lat       = 0;
        seen      = 0;
        while (!seen && lat < ((r.exp_lat == 0) ? 8 : 20)) begin
            @(posedge clk);
            lat++;
            if (done) seen = 1;
            else check_flag("busy", busy, r.exp_lat != 0);
            if (lat == 1 && r.exp_lat != 0) begin
                check_addr(addr, ea); // first byte cycle on the bus
                check_flag("we", we, r.req.write);
            end
            #1;
            halt = (lat < r.halt_n);
        end
        if (!seen && r.exp_lat != 0) begin
            $display("row %0d: done never came within %0d cycles", idx, lat);
            err_cnt++;
        end
        check_latency(seen ? lat : 0, r.exp_lat);
        check_rsp(rsp, exp);
        if (seen) last_rsp = exp;
        if (r.req.write && r.exp_lat != 0) begin
            if (r.req.wide) begin
                shadow[ea]         = r.wdata[15:8];
                shadow[ea + 16'd1] = r.wdata[7:0];
            end else begin
                shadow[ea] = r.wdata[7:0];
            end
        end
        $display("row %0d src %0d wide %0b write %0b halt %0d latency %0d: %s", idx,
                 r.req.src, r.req.wide, r.req.write, r.halt_n, seen ? lat : 0,
                 (err_cnt == errs_before) ? "ok" : "FAIL");
        if (err_cnt == errs_before) pass_cnt++;
        else fail_cnt++;
    endtask

    task automatic set_word(input logic [15:0] a, input logic [15:0] v);
        mem[a]            = v[15:8];
        mem[a + 16'd1]    = v[7:0];
        shadow[a]         = v[15:8];
        shadow[a + 16'd1] = v[7:0];
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned rnd;
        int          errs_before;
        addr_regs_t  g0;
        addr_regs_t  g1;
        addr_regs_t  g2;
        halt      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        regs      = '0;
        wdata     = '0;
        rnd = $urandom(32'haeae);
        for (int a = 0; a < 65536; a++) begin
            rnd       = $urandom;
            mem[a]    = rnd[7:0];
            shadow[a] = rnd[7:0];
        end
        set_word(`MEMCTRL_VEC_FIRQ, 16'hF12A);
        set_word(`MEMCTRL_VEC_IRQ,  16'h1C3D);
        set_word(`MEMCTRL_VEC_NMI,  16'h5E70);
        set_word(`MEMCTRL_VEC_RST,  16'h8001);
        g0 = '{16'h1234, 16'h2000, 16'h3FF0, 16'h0200, 16'h4100};
        g1 = '{16'h1234, 16'h2000, 16'h3FF0, 16'h01FE, 16'h4100}; // sp after the push
        g2 = '{16'h1234, 16'h2100, 16'h3FF0, 16'h0200, 16'h4100};
        rows[0]  = '{mk_req(SRC_PC,   0, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd2, 1, 0};
        rows[1]  = '{mk_req(SRC_X,    1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[2]  = '{mk_req(SRC_Y,    1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[3]  = '{mk_req(SRC_PULL, 1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[4]  = '{mk_req(SRC_IDX,  1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[5]  = '{mk_req(SRC_IDX,  1, 0, 1, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[6]  = '{mk_req(SRC_PUSH, 1, 1, 0, 4'h0), g0, 16'hBEEF, 4'd0, 4'd3, 0, 0};
        rows[7]  = '{mk_req(SRC_PULL, 1, 0, 0, 4'h0), g1, 16'h0000, 4'd0, 4'd3, 0, 0};
        rows[8]  = '{mk_req(SRC_VEC,  1, 0, 0, 4'h1), g0, 16'h0000, 4'd0, 4'd3, 0, 1};
        rows[9]  = '{mk_req(SRC_VEC,  0, 0, 0, 4'h6), g0, 16'h0000, 4'd0, 4'd3, 0, 1};
        rows[10] = '{mk_req(SRC_VEC,  1, 0, 0, 4'hF), g0, 16'h0000, 4'd0, 4'd3, 0, 1};
        rows[11] = '{mk_req(SRC_VEC,  1, 0, 0, 4'h2), g0, 16'h0000, 4'd0, 4'd3, 0, 1};
        rows[12] = '{mk_req(SRC_VEC,  1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd0, 0, 0};
        rows[13] = '{mk_req(SRC_X,    1, 0, 0, 4'h0), g0, 16'h0000, 4'd3, 4'd6, 0, 0};
        rows[14] = '{mk_req(SRC_PC,   0, 0, 0, 4'h0), g0, 16'h0000, 4'd2, 4'd4, 1, 0};
        rows[15] = '{mk_req(SRC_X,    0, 1, 0, 4'h0), g2, 16'h00A5, 4'd0, 4'd2, 0, 0};
        rows[16] = '{mk_req(SRC_X,    0, 0, 0, 4'h0), g2, 16'h0000, 4'd0, 4'd2, 0, 0};
        rows[17] = '{mk_req(SRC_Y,    1, 1, 0, 4'h0), g0, 16'hC0DE, 4'd2, 4'd5, 0, 0};
        rows[18] = '{mk_req(SRC_Y,    1, 0, 0, 4'h0), g0, 16'h0000, 4'd0, 4'd3, 0, 0};
        @(negedge rst);
        @(posedge clk);
        errs_before = err_cnt; // idle state out of reset
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("we", we, 1'b0);
        check_addr(addr, 16'h0000);
        check_rsp(rsp, '0);
        $display("reset state: %s", (err_cnt == errs_before) ? "ok" : "FAIL");
        if (err_cnt == errs_before) pass_cnt++;
        else fail_cnt++;
        for (int i = 0; i < NROWS; i++) run_row(i);
        $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb_clkgen.sv
// testbench clock and power-on reset
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // released 1 ns after an edge, same as the stimulus
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: memctrl_top.sv
// memory-access unit: address select, byte sequencer and capture stage
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module memctrl_top
    import cpu_mem_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,
    input  logic                   req_valid,
    input  mem_req_t               req,
    input  addr_regs_t             regs,
    input  logic [`MEMCTRL_AW-1:0] wdata,
    input  logic [`MEMCTRL_DW-1:0] din,
    output logic                   busy,
    output logic                   done,
    output mem_rsp_t               rsp,
    output logic [`MEMCTRL_AW-1:0] addr,
    output logic [`MEMCTRL_DW-1:0] dout,
    output logic                   we
);

    logic                   plan_valid;
    logic [`MEMCTRL_AW-1:0] plan_addr;
    logic [`MEMCTRL_AW-1:0] plan_wdata;
    mem_req_t               plan;
    logic                   seq_idle;
    byte_cycle_t            cycle;

    addr_select addr_select_i (
        .clk, .rst, .halt, .req_valid, .req, .regs, .wdata, .seq_idle,
        .plan_valid, .plan_addr, .plan, .plan_wdata, .busy
    );

    byte_sequencer byte_sequencer_i (
        .clk, .rst, .halt, .plan_valid, .plan_addr, .plan, .plan_wdata,
        .seq_idle, .cycle, .addr, .dout, .we
    );

    fetch_capture fetch_capture_i (
        .clk, .rst, .halt, .cycle, .plan, .din, .done, .rsp
    );

endmodule

// File: fetch_capture.sv
// read data assembly into the response word and done pulse
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module fetch_capture
    import cpu_mem_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,
    input  byte_cycle_t            cycle,
    input  mem_req_t               plan,
    input  logic [`MEMCTRL_DW-1:0] din,
    output logic                   done,
    output mem_rsp_t               rsp
);

    logic [`MEMCTRL_DW-1:0] hi_q; // first byte of a wide read
    logic                   fin;  // last byte on the bus this cycle

    assign fin = cycle.valid && cycle.last;

    // hold the high byte aside so rsp stays stable until the next done
    always_ff @(posedge clk) begin
        if (!halt && cycle.valid && cycle.is_read && cycle.which == BYTE_HI) begin
            hi_q <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
            rsp  <= '0;
        end else if (!halt) begin
            done <= fin;
            if (fin) begin
                rsp.is_op  <= (plan.src == SRC_PC) && !plan.wide && !plan.write;
                rsp.is_vec <= (plan.src == SRC_VEC);
                // writes keep the previous data
                if (cycle.is_read) begin
                    rsp.data.bytes.hi <= plan.wide ? hi_q : '0;
                    rsp.data.bytes.lo <= din;
                end
            end
        end
    end

endmodule

// File: byte_sequencer.sv
// byte stepper: one or two bus cycles per access, write data and enable
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module byte_sequencer
    import cpu_mem_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,
    input  logic                   plan_valid,
    input  logic [`MEMCTRL_AW-1:0] plan_addr,
    input  mem_req_t               plan,
    input  logic [`MEMCTRL_AW-1:0] plan_wdata,
    output logic                   seq_idle,
    output byte_cycle_t            cycle,
    output logic [`MEMCTRL_AW-1:0] addr,
    output logic [`MEMCTRL_DW-1:0] dout,
    output logic                   we
);

    typedef enum logic {
        SEQ_FIRST,  // idle, or first byte while plan_valid is high
        SEQ_SECOND  // low byte of a wide access
    } seq_state_e;

    seq_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_FIRST;
        end else if (!halt) begin
            case (state)
                SEQ_FIRST: begin
                    if (plan_valid && plan.wide) state <= SEQ_SECOND;
                end
                SEQ_SECOND: begin
                    state <= SEQ_FIRST; // never more than two bytes
                end
                default: state <= SEQ_FIRST;
            endcase
        end
    end

    assign seq_idle = (state == SEQ_FIRST);

    // bus side is combinational off the held plan, so the first byte
    // goes out in the cycle right after acceptance
    always_comb begin
        cycle.valid   = plan_valid || (state == SEQ_SECOND);
        cycle.is_read = !plan.write;
        if (state == SEQ_SECOND) begin
            cycle.which = BYTE_LO;
            cycle.last  = 1'b1;
            addr        = plan_addr + `MEMCTRL_AW'd1;
            dout        = plan_wdata[`MEMCTRL_DW-1:0];
        end else begin
            // wide starts with the high byte at the plan address
            cycle.which = plan.wide ? BYTE_HI : BYTE_LO;
            cycle.last  = !plan.wide;
            addr        = plan_addr;
            if (plan.wide) begin
                dout = plan_wdata[2*`MEMCTRL_DW-1:`MEMCTRL_DW];
            end else begin
                dout = plan_wdata[`MEMCTRL_DW-1:0]; // narrow write sends the low half
            end
        end
    end

    // held through halt, the repeated write hits the same byte
    assign we = cycle.valid && plan.write;

endmodule

// File: addr_select.sv
// request acceptance, start address selection and busy flag
`timescale 1ns/1ps
`include "memctrl_macros.svh"

module addr_select
    import cpu_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   halt,
    input  logic                   req_valid,
    input  mem_req_t               req,
    input  addr_regs_t             regs,
    input  logic [`MEMCTRL_AW-1:0] wdata,
    input  logic                   seq_idle,
    output logic                   plan_valid,
    output logic [`MEMCTRL_AW-1:0] plan_addr,
    output mem_req_t               plan,
    output logic [`MEMCTRL_AW-1:0] plan_wdata,
    output logic                   busy
);

    logic                   vec_ok;
    logic                   accept;
    logic [`MEMCTRL_AW-1:0] vec_addr;
    logic [`MEMCTRL_AW-1:0] push_step;
    logic [`MEMCTRL_AW-1:0] start_addr;
    mem_req_t               req_fix;

    // first byte cycle still pending or second byte on the bus
    assign busy = plan_valid | ~seq_idle;

    // a vector request without any code bit is dropped
    assign vec_ok = (req.src != SRC_VEC) || (req.intvec != '0);
    assign accept = req_valid && !busy && !halt && vec_ok;

    // highest set bit wins in the order rst nmi firq irq
    always_comb begin
        if (req.intvec[3])      vec_addr = `MEMCTRL_VEC_RST;
        else if (req.intvec[2]) vec_addr = `MEMCTRL_VEC_NMI;
        else if (req.intvec[1]) vec_addr = `MEMCTRL_VEC_FIRQ;
        else                    vec_addr = `MEMCTRL_VEC_IRQ;
    end

    // push writes the bytes right below sp
    assign push_step = req.wide ? `MEMCTRL_AW'd2 : `MEMCTRL_AW'd1;

    always_comb begin
        case (req.src)
            SRC_PC:   start_addr = regs.pc;
            SRC_X:    start_addr = regs.x;
            SRC_Y:    start_addr = regs.y;
            SRC_PUSH: start_addr = regs.sp - push_step;
            SRC_PULL: start_addr = regs.sp;
            SRC_IDX:  start_addr = regs.idx_base + {{(`MEMCTRL_AW-1){1'b0}}, req.idx_adv};
            SRC_VEC:  start_addr = vec_addr;
            default:  start_addr = regs.pc;
        endcase
    end

    // vectors are always a two-byte read
    always_comb begin
        req_fix       = req;
        req_fix.spare = '0;
        if (req.src == SRC_VEC) begin
            req_fix.wide  = 1'b1;
            req_fix.write = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            plan_valid <= 1'b0;
            plan_addr  <= '0;   // bus address reads zero out of reset
            plan       <= '0;
        end else if (!halt) begin
            plan_valid <= accept; // high for the first byte cycle only
            if (accept) begin
                plan_addr <= start_addr;
                plan      <= req_fix;
            end
        end
    end

    // write data sampled with the request
    always_ff @(posedge clk) begin
        if (accept) plan_wdata <= wdata;
    end

endmodule

// File: mem_bus_pkg.sv
// memory-bus types: byte cycle, fetched word and response
`include "memctrl_macros.svh"

package mem_bus_pkg;

    typedef enum logic {
        BYTE_LO,
        BYTE_HI
    } byte_sel_e;

    // one byte transfer on the bus, seen by the capture stage
    typedef struct packed {
        logic      valid;
        byte_sel_e which;   // half of the word this byte belongs to
        logic      last;    // final byte of the access
        logic      is_read;
    } byte_cycle_t;

    typedef struct packed {
        logic [`MEMCTRL_DW-1:0] hi;
        logic [`MEMCTRL_DW-1:0] lo;
    } fetch_bytes_t;

    // filled byte by byte, read back as one word
    typedef union packed {
        logic [2*`MEMCTRL_DW-1:0] word;
        fetch_bytes_t             bytes;
    } fetch_word_u;

    typedef struct packed {
        fetch_word_u data;
        logic        is_op;  // narrow pc read
        logic        is_vec; // vector fetch
    } mem_rsp_t;

endpackage

// File: cpu_mem_pkg.sv
// cpu-side types: address source, request word and pointer snapshot
`include "memctrl_macros.svh"

package cpu_mem_pkg;

    // where the start address comes from
    typedef enum logic [2:0] {
        SRC_PC,   // program counter, opcode fetch when narrow
        SRC_X,
        SRC_Y,
        SRC_PUSH, // pre-decremented stack pointer
        SRC_PULL, // stack pointer as is
        SRC_IDX,  // indexed base, optional +1
        SRC_VEC   // interrupt vector table
    } addr_src_e;

    // pointer values sampled with the request
    typedef struct packed {
        logic [`MEMCTRL_AW-1:0] pc;
        logic [`MEMCTRL_AW-1:0] x;
        logic [`MEMCTRL_AW-1:0] y;
        logic [`MEMCTRL_AW-1:0] sp;
        logic [`MEMCTRL_AW-1:0] idx_base;
    } addr_regs_t;

    typedef struct packed {
        addr_src_e                src;
        logic                     wide;    // two bytes, big-endian
        logic                     write;
        logic                     idx_adv; // second byte of an indexed pair
        logic [`MEMCTRL_INTW-1:0] intvec;  // one-hot, SRC_VEC only
        logic [1:0]               spare;   // kept at zero
    } mem_req_t;

endpackage

// File: memctrl_macros.svh
// bus widths and interrupt vector addresses for the memory-access unit
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// cpu address space and byte-wide memory bus
`define MEMCTRL_AW 16
`define MEMCTRL_DW 8

// vector table at the top of memory
// each entry is a big-endian word: high byte here, low byte at +1
`define MEMCTRL_VEC_IRQ  16'hFFF8
`define MEMCTRL_VEC_FIRQ 16'hFFF6
`define MEMCTRL_VEC_NMI  16'hFFFC
`define MEMCTRL_VEC_RST  16'hFFFE

// one-hot interrupt code width, bit 3 is the highest priority
`define MEMCTRL_INTW 4

`endif
